// File: digicam_cfg.svh
`ifndef DIGICAM_CFG_SVH
`define DIGICAM_CFG_SVH

// ======================================================================
// threshold control
// ======================================================================

// value loaded into the binary threshold on reset
`define DIGICAM_THR_RESET 8'd64

// change applied per up or down key press
`define DIGICAM_THR_STEP 8'd5

// saturation limits for the threshold register
`define DIGICAM_THR_MAX 8'd255
`define DIGICAM_THR_MIN 8'd0

// ======================================================================
// pixel pipeline latencies
// ======================================================================

// expand stage plus luma stage
`define DIGICAM_EXEC_LAT 2

// output colour select register
`define DIGICAM_RESULT_LAT 1

// pixel in to vga out is the sum of the two
// a vga pixel stream never stalls, so these are fixed
// the command path is separate and takes one cycle
// (key accepted, new mode visible on the next edge)

// mode and channel are read at the result stage
// the threshold is read when the pixel sits in the luma stage
// so a key landing mid-flight may split a pixel's view of them
// the stimulus keeps keys and pixels apart to avoid that

`endif

// File: digicam_filter.f
+incdir+.
digicam_pkg.sv
ir_command_decoder.sv
pixel_filter_pipe.sv
display_output_select.sv
digicam_filter_top.sv
tb_digicam_filter.sv

// File: digicam_filter_top.sv
`default_nettype none

`include "digicam_cfg.svh"

module digicam_filter_top (
    input  logic                        clk_25_vga,
    input  logic                        rst_n,
    // remote keys, decoded
    input  logic                        ir_valid,
    input  logic [7:0]                  ir_code,
    // camera pixel stream
    input  logic                        pixel_valid,
    input  logic [15:0]                 pixel_rgb565,
    // to the vga dac
    output logic                        vga_valid,
    output logic [7:0]                  vga_r,
    output logic [7:0]                  vga_g,
    output logic [7:0]                  vga_b,
    // front panel status
    output digicam_pkg::display_mode_e  cur_mode,
    output logic [7:0]                  cur_threshold
);

    // ==================================================================
    // internal nets
    // ==================================================================

    digicam_pkg::channel_sel_e channel;

    logic       stage_valid;
    logic [7:0] r8;
    logic [7:0] g8;
    logic [7:0] b8;
    logic [7:0] luma;
    logic       above_thr;

    // decode, key codes to mode and threshold
    ir_command_decoder decode (
        .clk_25_vga (clk_25_vga),
        .rst_n      (rst_n),
        .ir_valid   (ir_valid),
        .ir_code    (ir_code),
        .mode       (cur_mode),
        .channel    (channel),
        .threshold  (cur_threshold)
    );

    // execute, expand + luma + compare
    pixel_filter_pipe execute (
        .clk_25_vga   (clk_25_vga),
        .rst_n        (rst_n),
        .pixel_valid  (pixel_valid),
        .pixel_rgb565 (pixel_rgb565),
        .threshold    (cur_threshold),
        .stage_valid  (stage_valid),
        .r8           (r8),
        .g8           (g8),
        .b8           (b8),
        .luma         (luma),
        .above_thr    (above_thr)
    );

    // result, pick colour per mode
    display_output_select result (
        .clk_25_vga  (clk_25_vga),
        .rst_n       (rst_n),
        .stage_valid (stage_valid),
        .r8          (r8),
        .g8          (g8),
        .b8          (b8),
        .luma        (luma),
        .above_thr   (above_thr),
        .mode        (cur_mode),
        .channel     (channel),
        .vga_valid   (vga_valid),
        .vga_r       (vga_r),
        .vga_g       (vga_g),
        .vga_b       (vga_b)
    );

    // every accepted pixel reaches the dac after the fixed pipeline depth
    a_pixel_latency: assert property (
        @(posedge clk_25_vga) disable iff (!rst_n)
        pixel_valid |-> ##(`DIGICAM_EXEC_LAT + `DIGICAM_RESULT_LAT) vga_valid
    );

endmodule

`default_nettype wire

// File: digicam_pkg.sv
`default_nettype none

package digicam_pkg;

    // ==================================================================
    // display modes
    // ==================================================================

    typedef enum logic [1:0] {
        MODE_ORIG    = 2'd0,  // expanded rgb888 as is
        MODE_GRAY    = 2'd1,  // luma on all channels
        MODE_THRESH  = 2'd2,  // black or white by luma compare
        MODE_CHANNEL = 2'd3   // one colour channel only
    } display_mode_e;

    // ==================================================================
    // remote key opcodes, already decoded upstream
    // ==================================================================

    typedef enum logic [7:0] {
        KEY_RED    = 8'h01,  // key 1
        KEY_GREEN  = 8'h02,  // key 2
        KEY_BLUE   = 8'h03,  // key 3
        KEY_GRAY   = 8'h0F,
        KEY_ORIG   = 8'h12,  // ok key
        KEY_THRESH = 8'h13,
        KEY_UP     = 8'h1A,  // threshold up
        KEY_DOWN   = 8'h1E   // threshold down
    } ir_key_e;

    // ==================================================================
    // channel select for single-channel view
    // ==================================================================

    typedef enum logic [1:0] {
        CH_RED   = 2'd0,
        CH_GREEN = 2'd1,
        CH_BLUE  = 2'd2
        // 2'd3 unused
    } channel_sel_e;

endpackage

`default_nettype wire

// File: display_output_select.sv
`default_nettype none

module display_output_select (
    input  logic                        clk_25_vga,
    input  logic                        rst_n,
    input  logic                        stage_valid,
    input  logic [7:0]                  r8,
    input  logic [7:0]                  g8,
    input  logic [7:0]                  b8,
    input  logic [7:0]                  luma,
    input  logic                        above_thr,
    input  digicam_pkg::display_mode_e  mode,     // read at this stage
    input  digicam_pkg::channel_sel_e   channel,
    output logic                        vga_valid,
    output logic [7:0]                  vga_r,
    output logic [7:0]                  vga_g,
    output logic [7:0]                  vga_b
);

    // ==================================================================
    // colour mux by display mode
    // ==================================================================

    logic [7:0] next_r;
    logic [7:0] next_g;
    logic [7:0] next_b;
    logic [7:0] bw;       // white or black for threshold view

    assign bw = above_thr ? 8'hFF : 8'h00;

    always_comb begin
        next_r = 8'd0;  // black outside the active area
        next_g = 8'd0;
        next_b = 8'd0;
        if (stage_valid) begin
            case (mode)
                digicam_pkg::MODE_ORIG: begin
                    next_r = r8;
                    next_g = g8;
                    next_b = b8;
                end
                digicam_pkg::MODE_GRAY: begin
                    next_r = luma;
                    next_g = luma;
                    next_b = luma;
                end
                digicam_pkg::MODE_THRESH: begin
                    next_r = bw;
                    next_g = bw;
                    next_b = bw;
                end
                digicam_pkg::MODE_CHANNEL: begin
                    // other two channels stay black
                    case (channel)
                        digicam_pkg::CH_RED:   next_r = r8;
                        digicam_pkg::CH_GREEN: next_g = g8;
                        digicam_pkg::CH_BLUE:  next_b = b8;
                        default: ;  // unused code shows black
                    endcase
                end
                default: ;
            endcase
        end
    end

    // output register
    always_ff @(posedge clk_25_vga) begin
        if (!rst_n) begin
            vga_valid <= 1'b0;
            vga_r     <= 8'd0;
            vga_g     <= 8'd0;
            vga_b     <= 8'd0;
        end else begin
            vga_valid <= stage_valid;
            vga_r     <= next_r;
            vga_g     <= next_g;
            vga_b     <= next_b;
        end
    end

    // blanked output is black
    a_blank_black: assert property (
        @(posedge clk_25_vga) disable iff (!rst_n)
        !vga_valid |-> (vga_r == 8'd0 && vga_g == 8'd0 && vga_b == 8'd0)
    );

endmodule

`default_nettype wire

// File: ir_command_decoder.sv
`default_nettype none

`include "digicam_cfg.svh"

module ir_command_decoder (
    input  logic                        clk_25_vga,
    input  logic                        rst_n,
    input  logic                        ir_valid,   // one-cycle key strobe
    input  logic [7:0]                  ir_code,    // decoded key code
    output digicam_pkg::display_mode_e  mode,
    output digicam_pkg::channel_sel_e   channel,
    output logic [7:0]                  threshold
);

    // ==================================================================
    // key decode and threshold stepping
    // ==================================================================

    digicam_pkg::ir_key_e key;
    logic [8:0]           thr_up_sum;   // one spare bit for overflow
    logic [7:0]           thr_up;
    logic [7:0]           thr_down;

    assign key = digicam_pkg::ir_key_e'(ir_code);  // raw code viewed as opcode

    assign thr_up_sum = {1'b0, threshold} + {1'b0, `DIGICAM_THR_STEP};

    // clamp at the top
    assign thr_up = (thr_up_sum > {1'b0, `DIGICAM_THR_MAX}) ? `DIGICAM_THR_MAX
                                                            : thr_up_sum[7:0];

    // clamp at the bottom so it never wraps below min
    assign thr_down = (threshold < (`DIGICAM_THR_MIN + `DIGICAM_THR_STEP))
                    ? `DIGICAM_THR_MIN
                    : threshold - `DIGICAM_THR_STEP;

    // ==================================================================
    // registered control state
    // ==================================================================

    always_ff @(posedge clk_25_vga) begin
        if (!rst_n) begin
            mode      <= digicam_pkg::MODE_ORIG;
            channel   <= digicam_pkg::CH_RED;
            threshold <= `DIGICAM_THR_RESET;
        end else if (ir_valid) begin
            case (key)
                digicam_pkg::KEY_ORIG:   mode <= digicam_pkg::MODE_ORIG;
                digicam_pkg::KEY_GRAY:   mode <= digicam_pkg::MODE_GRAY;
                digicam_pkg::KEY_THRESH: mode <= digicam_pkg::MODE_THRESH;
                digicam_pkg::KEY_RED: begin
                    mode    <= digicam_pkg::MODE_CHANNEL;
                    channel <= digicam_pkg::CH_RED;
                end
                digicam_pkg::KEY_GREEN: begin
                    mode    <= digicam_pkg::MODE_CHANNEL;
                    channel <= digicam_pkg::CH_GREEN;
                end
                digicam_pkg::KEY_BLUE: begin
                    mode    <= digicam_pkg::MODE_CHANNEL;
                    channel <= digicam_pkg::CH_BLUE;
                end
                digicam_pkg::KEY_UP:     threshold <= thr_up;
                digicam_pkg::KEY_DOWN:   threshold <= thr_down;
                default: begin
                    // unknown remote code holds the state
                end
            endcase
        end
    end

    // ==================================================================
    // checks
    // ==================================================================

    // mode and channel stay on defined encodings once out of reset
    a_legal_state: assert property (
        @(posedge clk_25_vga) disable iff (!rst_n)
        !$isunknown(mode) &&
        channel inside {digicam_pkg::CH_RED, digicam_pkg::CH_GREEN,
                        digicam_pkg::CH_BLUE}
    );

endmodule

`default_nettype wire

// File: pixel_filter_pipe.sv
`default_nettype none

module pixel_filter_pipe (
    input  logic        clk_25_vga,
    input  logic        rst_n,
    input  logic        pixel_valid,   // active-area flag
    input  logic [15:0] pixel_rgb565,  // r[15:11] g[10:5] b[4:0]
    input  logic [7:0]  threshold,     // binary threshold from decoder
    output logic        stage_valid,
    output logic [7:0]  r8,
    output logic [7:0]  g8,
    output logic [7:0]  b8,
    output logic [7:0]  luma,
    output logic        above_thr      // luma >= threshold
);

    // ==================================================================
    // stage 1 expands rgb565 to rgb888
    // ==================================================================

    logic [7:0] exp_r;
    logic [7:0] exp_g;
    logic [7:0] exp_b;

    logic       s1_valid;
    logic [7:0] s1_r;
    logic [7:0] s1_g;
    logic [7:0] s1_b;

    // low bits filled with ones
    assign exp_r = {pixel_rgb565[15:11], 3'b111};
    assign exp_g = {pixel_rgb565[10:5],  2'b11};
    assign exp_b = {pixel_rgb565[4:0],   3'b111};

    always_ff @(posedge clk_25_vga) begin
        if (!rst_n) begin
            s1_valid <= 1'b0;
            s1_r     <= 8'd0;
            s1_g     <= 8'd0;
            s1_b     <= 8'd0;
        end else begin
            s1_valid <= pixel_valid;
            // blanked pixels carry zero data
            s1_r     <= pixel_valid ? exp_r : 8'd0;
            s1_g     <= pixel_valid ? exp_g : 8'd0;
            s1_b     <= pixel_valid ? exp_b : 8'd0;
        end
    end

    // ==================================================================
    // stage 2 computes luma and the threshold compare
    // ==================================================================

    logic [15:0] luma_sum;   // at most 252 * 255 so 16 bits suffice
    logic [7:0]  luma_next;
    logic        thr_hit;

    // weights 76/150/26 out of 256
    assign luma_sum = 16'd76  * {8'd0, s1_r}
                    + 16'd150 * {8'd0, s1_g}
                    + 16'd26  * {8'd0, s1_b};

    assign luma_next = luma_sum[15:8];  // divide by 256 with truncation

    // threshold as it stands while the pixel is in this stage
    assign thr_hit = s1_valid && (luma_next >= threshold);

    always_ff @(posedge clk_25_vga) begin
        if (!rst_n) begin
            stage_valid <= 1'b0;
            r8          <= 8'd0;
            g8          <= 8'd0;
            b8          <= 8'd0;
            luma        <= 8'd0;
            above_thr   <= 1'b0;
        end else begin
            stage_valid <= s1_valid;
            r8          <= s1_r;  // already zero when blanked
            g8          <= s1_g;
            b8          <= s1_b;
            luma        <= s1_valid ? luma_next : 8'd0;
            above_thr   <= thr_hit;
        end
    end

    // ==================================================================
    // checks
    // ==================================================================

    // blanked slots leave this stage as all zero
    a_blank_zero: assert property (
        @(posedge clk_25_vga) disable iff (!rst_n)
        !stage_valid |-> (r8 == 8'd0 && g8 == 8'd0 && b8 == 8'd0 &&
                          luma == 8'd0 && !above_thr)
    );

endmodule

`default_nettype wire

// File: tb_digicam_filter.sv
`default_nettype none

`include "digicam_cfg.svh"

module tb_digicam_filter;

    localparam int CLK_PERIOD = 40;
    localparam int LAT        = `DIGICAM_EXEC_LAT + `DIGICAM_RESULT_LAT;
    localparam int ROW_CYCLES = 20;             // key, gap, pixel, drain, gap
    localparam int TAB_MAX    = 40;
    localparam logic [8:0]  NO_KEY = 9'h000;
    localparam logic [8:0]  NO_THR = 9'h100;    // bit 8 set means no threshold check
    localparam logic [16:0] RND    = 17'h10000; // bit 16 set means a random pixel

    logic                       clk_25_vga;
    logic                       rst_n;
    logic                       ir_valid;
    logic [7:0]                 ir_code;
    logic                       pixel_valid;
    logic [15:0]                pixel_rgb565;
    logic                       vga_valid;
    logic [7:0]                 vga_r;
    logic [7:0]                 vga_g;
    logic [7:0]                 vga_b;
    digicam_pkg::display_mode_e cur_mode;
    logic [7:0]                 cur_threshold;

    // stimulus table with one entry per row
    logic [8:0]  tab_key [0:TAB_MAX-1];  // {present, code}
    logic [16:0] tab_pix [0:TAB_MAX-1];  // {random, value}
    logic        tab_vld [0:TAB_MAX-1];
    int          tab_reps [0:TAB_MAX-1];
    logic [8:0]  tab_thr [0:TAB_MAX-1];  // threshold expected after last key
    int          n_rows;
    int          total_reps;
    logic        table_ready;
    int          n_errors;
    int          n_checks;
    int unsigned seed_val;
    int unsigned rnd_word;

    // reference model state
    digicam_pkg::display_mode_e m_mode;
    digicam_pkg::channel_sel_e  m_channel;
    int                         m_thr;

    digicam_filter_top digicam_filter_top_inst (
        .clk_25_vga    (clk_25_vga),
        .rst_n         (rst_n),
        .ir_valid      (ir_valid),
        .ir_code       (ir_code),
        .pixel_valid   (pixel_valid),
        .pixel_rgb565  (pixel_rgb565),
        .vga_valid     (vga_valid),
        .vga_r         (vga_r),
        .vga_g         (vga_g),
        .vga_b         (vga_b),
        .cur_mode      (cur_mode),
        .cur_threshold (cur_threshold)
    );

    initial begin
        clk_25_vga = 1'b0;
        forever #(CLK_PERIOD / 2) clk_25_vga = ~clk_25_vga;
    end

    // ======================================================================
    // reference model
    // ======================================================================

    function automatic logic [23:0] expected_colour(input logic [15:0] pix, input logic vld);
        int r;
        int g;
        int b;
        int y;
        logic [7:0] bw;
        r = int'(pix[15:11]) * 8 + 7;   // low bits filled with ones
        g = int'(pix[10:5]) * 4 + 3;
        b = int'(pix[4:0]) * 8 + 7;
        y = (76 * r + 150 * g + 26 * b) / 256;
        bw = (y >= m_thr) ? 8'hFF : 8'h00;
        if (!vld)
            return 24'h0;
        case (m_mode)
            digicam_pkg::MODE_GRAY:   return {8'(y), 8'(y), 8'(y)};
            digicam_pkg::MODE_THRESH: return {bw, bw, bw};
            digicam_pkg::MODE_CHANNEL: begin
                if (m_channel == digicam_pkg::CH_RED)
                    return {8'(r), 16'h0};
                else if (m_channel == digicam_pkg::CH_GREEN)
                    return {8'h0, 8'(g), 8'h0};
                else
                    return {16'h0, 8'(b)};
            end
            default:                  return {8'(r), 8'(g), 8'(b)};
        endcase
    endfunction

    task automatic update_model(input logic [7:0] code);
        case (code)
            digicam_pkg::KEY_ORIG:   m_mode = digicam_pkg::MODE_ORIG;
            digicam_pkg::KEY_GRAY:   m_mode = digicam_pkg::MODE_GRAY;
            digicam_pkg::KEY_THRESH: m_mode = digicam_pkg::MODE_THRESH;
            digicam_pkg::KEY_RED: begin
                m_mode    = digicam_pkg::MODE_CHANNEL;
                m_channel = digicam_pkg::CH_RED;
            end
            digicam_pkg::KEY_GREEN: begin
                m_mode    = digicam_pkg::MODE_CHANNEL;
                m_channel = digicam_pkg::CH_GREEN;
            end
            digicam_pkg::KEY_BLUE: begin
                m_mode    = digicam_pkg::MODE_CHANNEL;
                m_channel = digicam_pkg::CH_BLUE;
            end
            digicam_pkg::KEY_UP:     m_thr = (m_thr + 5 > 255) ? 255 : m_thr + 5;
            digicam_pkg::KEY_DOWN:   m_thr = (m_thr < 5) ? 0 : m_thr - 5;
            default: ;               // unknown code moves nothing
        endcase
    endtask

    task automatic check_value(input string name, input logic [7:0] exp, input logic [7:0] act);
        n_checks++;
        if (act !== exp) begin
            n_errors++;
            $display("Mismatch at %0t: %s expected %02h, got %02h", $time, name, exp, act);
        end
    endtask

    // ======================================================================
    // drivers are entered and left 2 units after a rising edge
    // ======================================================================

    task automatic send_key(input logic [7:0] code);
        ir_valid = 1'b1;
        ir_code  = code;
        @(posedge clk_25_vga);
        #2;
        ir_valid = 1'b0;
        ir_code  = 8'h00;
        update_model(code);                  // decoder output is one cycle later
        check_value("cur_mode", 8'(m_mode), 8'(cur_mode));
        check_value("cur_threshold", 8'(m_thr), cur_threshold);
        repeat (4) @(posedge clk_25_vga);    // keep keys apart from pixels
        #2;
    endtask

    task automatic send_pixel(input logic [15:0] pix, input logic vld);
        logic [23:0] exp;
        exp          = expected_colour(pix, vld);
        pixel_valid  = vld;
        pixel_rgb565 = pix;                  // data driven even when blanked
        @(posedge clk_25_vga);
        #2;
        pixel_valid  = 1'b0;
        pixel_rgb565 = 16'h0000;
        repeat (LAT - 1) @(posedge clk_25_vga);
        #2;
        check_value("vga_valid", {7'd0, vld}, {7'd0, vga_valid});
        check_value("vga_r", exp[23:16], vga_r);
        check_value("vga_g", exp[15:8], vga_g);
        check_value("vga_b", exp[7:0], vga_b);
        repeat (4) @(posedge clk_25_vga);
        #2;
    endtask

    task automatic add_row(input logic [8:0] key, input logic [16:0] pix, input logic vld,
                           input int reps, input logic [8:0] thr);
        tab_key[n_rows]  = key;
        tab_pix[n_rows]  = pix;
        tab_vld[n_rows]  = vld;
        tab_reps[n_rows] = reps;
        tab_thr[n_rows]  = thr;
        total_reps += reps;
        n_rows++;
    endtask

    task automatic build_table;
        add_row(NO_KEY, 17'h0FFFF, 1'b1, 1, NO_THR);      // white in reset mode
        add_row(NO_KEY, 17'h00000, 1'b1, 1, NO_THR);      // black shows filled low bits
        add_row(NO_KEY, RND, 1'b1, 4, NO_THR);
        add_row(NO_KEY, RND, 1'b0, 2, NO_THR);            // blanked in orig
        add_row({1'b1, 8'h0F}, RND, 1'b1, 6, NO_THR);     // gray
        add_row(NO_KEY, RND, 1'b0, 1, NO_THR);
        add_row({1'b1, 8'h13}, 17'h039E9, 1'b1, 1, 9'd64); // thresh with luma 63
        add_row(NO_KEY, 17'h03A07, 1'b1, 1, NO_THR);      // luma 64
        add_row(NO_KEY, 17'h04A6A, 1'b1, 1, NO_THR);      // luma 78
        add_row(NO_KEY, 17'h04A6B, 1'b1, 1, NO_THR);      // luma 79
        add_row({1'b1, 8'h1A}, RND, 1'b0, 3, 9'd79);      // three steps up
        add_row(NO_KEY, 17'h039E9, 1'b1, 1, NO_THR);
        add_row(NO_KEY, 17'h03A07, 1'b1, 1, NO_THR);
        add_row(NO_KEY, 17'h04A6A, 1'b1, 1, NO_THR);
        add_row(NO_KEY, 17'h04A6B, 1'b1, 1, NO_THR);
        add_row({1'b1, 8'h1E}, 17'h00000, 1'b1, 18, 9'd0);   // floor at 0
        add_row({1'b1, 8'h1A}, 17'h0FFFF, 1'b1, 53, 9'd255); // ceiling at 255
        add_row({1'b1, 8'h01}, RND, 1'b1, 3, NO_THR);     // red only
        add_row({1'b1, 8'h02}, RND, 1'b1, 3, NO_THR);
        add_row({1'b1, 8'h03}, RND, 1'b1, 3, NO_THR);
        add_row({1'b1, 8'h55}, RND, 1'b1, 2, 9'd255);     // unknown key keeps blue view
        add_row(NO_KEY, RND, 1'b0, 2, NO_THR);
        add_row({1'b1, 8'h12}, RND, 1'b1, 2, NO_THR);     // back to orig
    endtask

    // ======================================================================
    // main sequence and watchdog
    // ======================================================================

    initial begin
        ir_valid     = 1'b0;
        ir_code      = 8'h00;
        pixel_valid  = 1'b0;
        pixel_rgb565 = 16'h0000;
        rst_n        = 1'b0;
        n_errors     = 0;
        n_checks     = 0;
        n_rows       = 0;
        total_reps   = 0;
        table_ready  = 1'b0;
        seed_val     = 32'h9fa1;
        rnd_word     = $urandom(seed_val);   // seeds the generator
        m_mode       = digicam_pkg::MODE_ORIG;
        m_channel    = digicam_pkg::CH_RED;
        m_thr        = 64;
        build_table();
        table_ready  = 1'b1;
        repeat (2) @(posedge clk_25_vga);
        #2;
        rst_n = 1'b1;
        check_value("cur_mode", 8'(digicam_pkg::MODE_ORIG), 8'(cur_mode));
        check_value("cur_threshold", 8'd64, cur_threshold);
        check_value("vga_valid", 8'd0, {7'd0, vga_valid});
        for (int row = 0; row < n_rows; row++) begin
            for (int k = 0; k < tab_reps[row]; k++) begin
                if (tab_key[row][8]) begin
                    send_key(tab_key[row][7:0]);
                    if (!tab_thr[row][8] && k == tab_reps[row] - 1)
                        check_value("cur_threshold", tab_thr[row][7:0], cur_threshold);
                end
                rnd_word = $urandom;
                send_pixel(tab_pix[row][16] ? rnd_word[15:0] : tab_pix[row][15:0],
                           tab_vld[row]);
            end
        end
        $display("checks: %0d, errors: %0d", n_checks, n_errors);
        if (n_errors == 0)
            $display("ALL TESTS PASSED");
        else
            $display("SOME TESTS FAILED");
        $finish;
    end

    initial begin
        wait (table_ready);
        #(total_reps * ROW_CYCLES * CLK_PERIOD + 100 * CLK_PERIOD);
        $display("timeout: stimulus table did not finish within the expected time");
        $display("SOME TESTS FAILED");
        $finish;
    end

endmodule

`default_nettype wire
